//--- include/ifd_cfg.svh
/*
 * Fetch/decode configuration. Field widths must sum to the instruction word
 * width, and IFD_THREAD_W / IFD_IMEM_ADDR_W must match their counts.
 */
`ifndef IFD_CFG_SVH
`define IFD_CFG_SVH

// ---------------------------------------------------------------------------
// Threading
// ---------------------------------------------------------------------------
`define IFD_THREADS         4
`define IFD_THREAD_W        2
// Thread t starts fetching at t * stride
`define IFD_THREAD_STRIDE   64

// ---------------------------------------------------------------------------
// Shared instruction memory
// ---------------------------------------------------------------------------
`define IFD_IMEM_DEPTH      256
`define IFD_IMEM_ADDR_W     8

// ---------------------------------------------------------------------------
// Instruction fields, most to least significant
// ---------------------------------------------------------------------------
`define IFD_OPCODE_W        4
`define IFD_D_W             12
`define IFD_A_W             10
`define IFD_B_W             10

// ALU control word, top bit selects split addressing
`define IFD_CTRL_W          16
// Split addressing, DA from low half of D, DB from base plus high half
`define IFD_SPLIT_W         6
`define IFD_DB_BASE         12'h800

// Bundles the downstream stage can accept without a ready
`define IFD_CREDITS         4

`endif

//--- hw/ifd_pkg.sv
/*
 * Shared types for the fetch/decode front end. Widths come from ifd_cfg.svh.
 */
`default_nettype none

`include "ifd_cfg.svh"

package ifd_pkg;

    // -----------------------------------------------------------------------
    // Instruction word, opcode in the top bits
    // -----------------------------------------------------------------------
    typedef struct packed {
        logic [`IFD_OPCODE_W-1:0] opcode;
        logic [`IFD_D_W-1:0]      d;
        logic [`IFD_A_W-1:0]      a;
        logic [`IFD_B_W-1:0]      b;
    } instr_t;

    // -----------------------------------------------------------------------
    // ALU control word
    // -----------------------------------------------------------------------
    // Split selects the two-address form of D
    // Remaining bits go to the ALU untouched
    typedef struct packed {
        logic                     split;
        logic [`IFD_CTRL_W-2:0]   alu_op;
    } ctrl_t;

    // Hardware thread index
    typedef logic [`IFD_THREAD_W-1:0] thread_t;

    // Word address into the shared instruction memory
    typedef logic [`IFD_IMEM_ADDR_W-1:0] iaddr_t;

endpackage

`default_nettype wire

//--- hw/thread_sequencer.sv
/*
 * Round-robin issue with no branches, so each PC just increments and wraps.
 * A request waits on credit and on the arbiter, and retries unchanged.
 */
`timescale 1ns/100ps
`default_nettype none

`include "ifd_cfg.svh"

module thread_sequencer (
    input  wire                 clock,
    input  wire                 rst_n,
    input  wire                 credit_return,
    output logic                fetch_req,
    output ifd_pkg::iaddr_t     fetch_addr,
    output ifd_pkg::thread_t    fetch_thread,
    input  wire                 fetch_grant
);

    // Counter must hold the full credit count
    localparam int CREDIT_W = $clog2(`IFD_CREDITS + 1);

    logic                  run;
    logic [CREDIT_W-1:0]   credits;
    logic                  issue;
    ifd_pkg::thread_t      cur_thread;
    ifd_pkg::thread_t      next_thread;
    ifd_pkg::iaddr_t       pc [`IFD_THREADS];
    ifd_pkg::iaddr_t       next_pc;

    // -----------------------------------------------------------------------
    // Request and issue
    // -----------------------------------------------------------------------
    // Run flag keeps the request low until the first edge out of reset
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            run <= 1'b0;
        end else begin
            run <= 1'b1;
        end
    end

    assign fetch_req    = run && (credits != '0);
    // Issue only when the arbiter hands over the port
    assign issue        = fetch_req && fetch_grant;
    assign fetch_addr   = pc[cur_thread];
    assign fetch_thread = cur_thread;

    // -----------------------------------------------------------------------
    // Credit counter
    // -----------------------------------------------------------------------
    // Issue and return together cancel out
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            credits <= CREDIT_W'(`IFD_CREDITS);
        end else if (issue && !credit_return) begin
            credits <= credits - 1'b1;
        end else if (!issue && credit_return) begin
            credits <= credits + 1'b1;
        end
    end

    // -----------------------------------------------------------------------
    // Thread pointer and program counters
    // -----------------------------------------------------------------------
    // Wrap at memory depth and at the last thread
    assign next_pc = (fetch_addr == `IFD_IMEM_ADDR_W'(`IFD_IMEM_DEPTH - 1))
                   ? '0 : fetch_addr + 1'b1;
    assign next_thread = (cur_thread == `IFD_THREAD_W'(`IFD_THREADS - 1))
                       ? '0 : cur_thread + 1'b1;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            cur_thread <= '0;
            // Each thread starts in its own stride of the memory
            for (int t = 0; t < `IFD_THREADS; t++) begin
                pc[t] <= `IFD_IMEM_ADDR_W'(t * `IFD_THREAD_STRIDE);
            end
        end else if (issue) begin
            pc[cur_thread] <= next_pc;
            cur_thread     <= next_thread;
        end
        // Not granted, so same thread and PC are offered again
    end

endmodule

`default_nettype wire

//--- hw/imem_arbiter.sv
/*
 * Single-port instruction memory shared by loader and fetch. Loader writes
 * have fixed priority and no ready, so fetch stalls while ld_valid is high.
 */
`timescale 1ns/100ps
`default_nettype none

`include "ifd_cfg.svh"

module imem_arbiter (
    input  wire                 clock,
    input  wire                 rst_n,
    // Loader write port
    input  wire                 ld_valid,
    input  wire ifd_pkg::iaddr_t  ld_addr,
    input  wire ifd_pkg::instr_t  ld_data,
    // Fetch read request
    input  wire                 fetch_req,
    input  wire ifd_pkg::iaddr_t  fetch_addr,
    input  wire ifd_pkg::thread_t fetch_thread,
    output logic                fetch_grant,
    // Read result, one cycle after grant
    output logic                rd_valid,
    output ifd_pkg::thread_t    rd_thread,
    output ifd_pkg::instr_t     rd_word
);

    // Shared code store, filled through the loader port
    ifd_pkg::instr_t mem [`IFD_IMEM_DEPTH];

    // -----------------------------------------------------------------------
    // Arbitration
    // -----------------------------------------------------------------------
    // Fetch gets the port only when the loader is idle
    assign fetch_grant = fetch_req && !ld_valid;

    // -----------------------------------------------------------------------
    // Memory port
    // -----------------------------------------------------------------------
    // One access per cycle, write or read
    always_ff @(posedge clock) begin
        if (ld_valid) begin
            mem[ld_addr] <= ld_data;
        end else if (fetch_grant) begin
            // Synchronous read, word lines up with rd_valid
            rd_word <= mem[fetch_addr];
        end
    end

    // -----------------------------------------------------------------------
    // Read tag
    // -----------------------------------------------------------------------
    // Thread travels with the word so the decoder picks the right table
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            rd_valid  <= 1'b0;
            rd_thread <= '0;
        end else begin
            rd_valid <= fetch_grant;
            if (fetch_grant) begin
                rd_thread <= fetch_thread;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/opcode_decoder.sv
/*
 * Per-thread decode table addressed by {thread, opcode}. Host writes land at
 * the next edge and may race a lookup of the same entry in that cycle.
 */
`timescale 1ns/100ps
`default_nettype none

`include "ifd_cfg.svh"

module opcode_decoder (
    input  wire                        clock,
    input  wire                        rst_n,
    // Host write port into the decode table
    input  wire                        od_wren,
    input  wire ifd_pkg::thread_t      od_thread,
    input  wire [`IFD_OPCODE_W-1:0]    od_opcode,
    input  wire ifd_pkg::ctrl_t        od_data,
    // Fetched word from the arbiter
    input  wire                        rd_valid,
    input  wire ifd_pkg::thread_t      rd_thread,
    input  wire ifd_pkg::instr_t       rd_word,
    // Decoded stage outputs
    output logic                       dec_valid,
    output ifd_pkg::thread_t           dec_thread,
    output ifd_pkg::ctrl_t             dec_ctrl,
    output logic [`IFD_D_W-1:0]        dec_d,
    output logic [`IFD_A_W-1:0]        dec_a,
    output logic [`IFD_B_W-1:0]        dec_b
);

    // One full opcode space per thread
    localparam int OD_ADDR_W = `IFD_THREAD_W + `IFD_OPCODE_W;
    localparam int OD_DEPTH  = `IFD_THREADS << `IFD_OPCODE_W;

    ifd_pkg::ctrl_t        table_mem [OD_DEPTH];
    logic [OD_ADDR_W-1:0]  wr_index;
    logic [OD_ADDR_W-1:0]  rd_index;

    // Thread in the high bits keeps each table contiguous
    assign wr_index = {od_thread, od_opcode};
    assign rd_index = {rd_thread, rd_word.opcode};

    // -----------------------------------------------------------------------
    // Table write and lookup
    // -----------------------------------------------------------------------
    always_ff @(posedge clock) begin
        if (od_wren) begin
            table_mem[wr_index] <= od_data;
        end
    end

    // Operands registered with the lookup so all outputs line up
    always_ff @(posedge clock) begin
        if (rd_valid) begin
            dec_ctrl <= table_mem[rd_index];
            dec_d    <= rd_word.d;
            dec_a    <= rd_word.a;
            dec_b    <= rd_word.b;
        end
    end

    // -----------------------------------------------------------------------
    // Stage control
    // -----------------------------------------------------------------------
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            dec_valid  <= 1'b0;
            dec_thread <= '0;
        end else begin
            dec_valid <= rd_valid;
            if (rd_valid) begin
                dec_thread <= rd_thread;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/address_splitter.sv
/*
 * Final stage. In split mode D becomes DA from its low half and DB from
 * IFD_DB_BASE plus its high half; otherwise both carry D unchanged.
 */
`timescale 1ns/100ps
`default_nettype none

`include "ifd_cfg.svh"

module address_splitter (
    input  wire                     clock,
    input  wire                     rst_n,
    input  wire                     dec_valid,
    input  wire ifd_pkg::thread_t   dec_thread,
    input  wire ifd_pkg::ctrl_t     dec_ctrl,
    input  wire [`IFD_D_W-1:0]      dec_d,
    input  wire [`IFD_A_W-1:0]      dec_a,
    input  wire [`IFD_B_W-1:0]      dec_b,
    output logic                    out_valid,
    output ifd_pkg::thread_t        out_thread,
    output ifd_pkg::ctrl_t          out_ctrl,
    output logic [`IFD_D_W-1:0]     out_da,
    output logic [`IFD_D_W-1:0]     out_db,
    output logic [`IFD_A_W-1:0]     out_a,
    output logic [`IFD_B_W-1:0]     out_b
);

    logic [`IFD_D_W-1:0] split_da;
    logic [`IFD_D_W-1:0] split_db;
    logic [`IFD_D_W-1:0] next_da;
    logic [`IFD_D_W-1:0] next_db;

    // -----------------------------------------------------------------------
    // Split rule
    // -----------------------------------------------------------------------
    // Low half zero-extended, high half offset into the DB window
    assign split_da = `IFD_D_W'(dec_d[`IFD_SPLIT_W-1:0]);
    assign split_db = `IFD_D_W'(`IFD_DB_BASE)
                    + `IFD_D_W'(dec_d[`IFD_D_W-1 -: `IFD_SPLIT_W]);

    assign next_da = dec_ctrl.split ? split_da : dec_d;
    assign next_db = dec_ctrl.split ? split_db : dec_d;

    // Bundle payload
    always_ff @(posedge clock) begin
        if (dec_valid) begin
            out_ctrl <= dec_ctrl;
            out_da   <= next_da;
            out_db   <= next_db;
            out_a    <= dec_a;
            out_b    <= dec_b;
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            out_valid  <= 1'b0;
            out_thread <= '0;
        end else begin
            out_valid <= dec_valid;
            if (dec_valid) begin
                out_thread <= dec_thread;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/fetch_decode_top.sv
/*
 * Barrel fetch/decode front end, three stages from grant to out_valid.
 * Downstream returns one credit per retired bundle and has no ready.
 */
`timescale 1ns/100ps
`default_nettype none

`include "ifd_cfg.svh"

module fetch_decode_top (
    input  wire                     clock,
    input  wire                     rst_n,
    // Instruction memory loader
    input  wire                     ld_valid,
    input  wire ifd_pkg::iaddr_t    ld_addr,
    input  wire ifd_pkg::instr_t    ld_data,
    // Decode table host writes
    input  wire                     od_wren,
    input  wire ifd_pkg::thread_t   od_thread,
    input  wire [`IFD_OPCODE_W-1:0] od_opcode,
    input  wire ifd_pkg::ctrl_t     od_data,
    // Downstream flow control
    input  wire                     credit_return,
    // Decoded bundle
    output logic                    out_valid,
    output ifd_pkg::thread_t        out_thread,
    output ifd_pkg::ctrl_t          out_ctrl,
    output logic [`IFD_D_W-1:0]     out_da,
    output logic [`IFD_D_W-1:0]     out_db,
    output logic [`IFD_A_W-1:0]     out_a,
    output logic [`IFD_B_W-1:0]     out_b
);

    // Sequencer to arbiter
    logic               fetch_req;
    logic               fetch_grant;
    ifd_pkg::iaddr_t    fetch_addr;
    ifd_pkg::thread_t   fetch_thread;

    // Arbiter to decoder
    logic               rd_valid;
    ifd_pkg::thread_t   rd_thread;
    ifd_pkg::instr_t    rd_word;

    // Decoder to splitter
    logic               dec_valid;
    ifd_pkg::thread_t   dec_thread;
    ifd_pkg::ctrl_t     dec_ctrl;
    logic [`IFD_D_W-1:0] dec_d;
    logic [`IFD_A_W-1:0] dec_a;
    logic [`IFD_B_W-1:0] dec_b;

    // -----------------------------------------------------------------------
    // Issue and fetch
    // -----------------------------------------------------------------------
    thread_sequencer thread_sequencer_inst (
        .clock          (clock),
        .rst_n          (rst_n),
        .credit_return  (credit_return),
        .fetch_req      (fetch_req),
        .fetch_addr     (fetch_addr),
        .fetch_thread   (fetch_thread),
        .fetch_grant    (fetch_grant)
    );

    // Stage 1, shared memory read
    imem_arbiter imem_arbiter_inst (
        .clock          (clock),
        .rst_n          (rst_n),
        .ld_valid       (ld_valid),
        .ld_addr        (ld_addr),
        .ld_data        (ld_data),
        .fetch_req      (fetch_req),
        .fetch_addr     (fetch_addr),
        .fetch_thread   (fetch_thread),
        .fetch_grant    (fetch_grant),
        .rd_valid       (rd_valid),
        .rd_thread      (rd_thread),
        .rd_word        (rd_word)
    );

    // -----------------------------------------------------------------------
    // Decode and split
    // -----------------------------------------------------------------------
    // Stage 2, per-thread opcode lookup
    opcode_decoder opcode_decoder_inst (
        .clock          (clock),
        .rst_n          (rst_n),
        .od_wren        (od_wren),
        .od_thread      (od_thread),
        .od_opcode      (od_opcode),
        .od_data        (od_data),
        .rd_valid       (rd_valid),
        .rd_thread      (rd_thread),
        .rd_word        (rd_word),
        .dec_valid      (dec_valid),
        .dec_thread     (dec_thread),
        .dec_ctrl       (dec_ctrl),
        .dec_d          (dec_d),
        .dec_a          (dec_a),
        .dec_b          (dec_b)
    );

    // Stage 3, D split and output register
    address_splitter address_splitter_inst (
        .clock          (clock),
        .rst_n          (rst_n),
        .dec_valid      (dec_valid),
        .dec_thread     (dec_thread),
        .dec_ctrl       (dec_ctrl),
        .dec_d          (dec_d),
        .dec_a          (dec_a),
        .dec_b          (dec_b),
        .out_valid      (out_valid),
        .out_thread     (out_thread),
        .out_ctrl       (out_ctrl),
        .out_da         (out_da),
        .out_db         (out_db),
        .out_a          (out_a),
        .out_b          (out_b)
    );

endmodule

`default_nettype wire

//--- test/tb_fetch_decode.sv
/*
 * Directed testbench for the fetch/decode front end. Memories are loaded via
 * the DUT ports; shadow copies of both memories and the PCs predict bundles.
 */
`timescale 1ns/100ps
`default_nettype none

`include "ifd_cfg.svh"

module tb_fetch_decode;

    // Run limit well above the length of all tests
    localparam int TIMEOUT_CYCLES = 4000;
    localparam int TABLE_DEPTH    = `IFD_THREADS << `IFD_OPCODE_W;
    localparam int CMP_W          = 36;

    logic                       clock = 1'b0;
    logic                       rst_n;
    logic                       ld_valid;
    ifd_pkg::iaddr_t            ld_addr;
    ifd_pkg::instr_t            ld_data;
    logic                       od_wren;
    ifd_pkg::thread_t           od_thread;
    logic [`IFD_OPCODE_W-1:0]   od_opcode;
    ifd_pkg::ctrl_t             od_data;
    logic                       credit_return;
    logic                       out_valid;
    ifd_pkg::thread_t           out_thread;
    ifd_pkg::ctrl_t             out_ctrl;
    logic [`IFD_D_W-1:0]        out_da;
    logic [`IFD_D_W-1:0]        out_db;
    logic [`IFD_A_W-1:0]        out_a;
    logic [`IFD_B_W-1:0]        out_b;

    // Shadow state of the DUT
    ifd_pkg::instr_t            shadow_imem [`IFD_IMEM_DEPTH];
    ifd_pkg::ctrl_t             shadow_table [TABLE_DEPTH];
    ifd_pkg::iaddr_t            shadow_pc [`IFD_THREADS];
    ifd_pkg::thread_t           exp_thread;

    // Bundle log with one entry per received bundle
    logic [`IFD_THREAD_W-1:0]   log_thread [$];
    logic [`IFD_CTRL_W-1:0]     log_ctrl [$];
    logic [`IFD_D_W-1:0]        log_da [$];
    logic [`IFD_D_W-1:0]        log_db [$];
    logic [`IFD_A_W-1:0]        log_a [$];

    // Credit loop where pending holds bundles not yet credited back
    int                         received;
    int                         pending;
    int                         credit_grant;
    bit                         credit_auto;

    // Watch for one rewritten address
    bit                         watch_armed;
    bit                         watch_seen;
    ifd_pkg::thread_t           watch_thread;
    ifd_pkg::iaddr_t            watch_addr;
    ifd_pkg::instr_t            watch_word;

    logic [31:0]                rng_state = 32'h1578_25e3;
    string                      cur_test;
    int                         errors;
    int                         checks;
    int                         test_err_start;
    int                         tests_run;
    int                         tests_passed;
    int                         cycles;

    fetch_decode_top fetch_decode_top_inst (
        .clock          (clock),
        .rst_n          (rst_n),
        .ld_valid       (ld_valid),
        .ld_addr        (ld_addr),
        .ld_data        (ld_data),
        .od_wren        (od_wren),
        .od_thread      (od_thread),
        .od_opcode      (od_opcode),
        .od_data        (od_data),
        .credit_return  (credit_return),
        .out_valid      (out_valid),
        .out_thread     (out_thread),
        .out_ctrl       (out_ctrl),
        .out_da         (out_da),
        .out_db         (out_db),
        .out_a          (out_a),
        .out_b          (out_b)
    );

    always #10 clock = ~clock;

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function ifd_pkg::instr_t random_instr();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = next_rand();
        lo = next_rand();
        return {hi[3:0], lo};
    endfunction

    // Expected {da, db} from D and the split bit
    function automatic logic [2*`IFD_D_W-1:0] split_rule(input logic [`IFD_D_W-1:0] d,
                                                         input logic split);
        logic [`IFD_D_W-1:0] da;
        logic [`IFD_D_W-1:0] db;
        if (split) begin
            da = `IFD_D_W'(d[`IFD_SPLIT_W-1:0]);
            db = `IFD_DB_BASE + `IFD_D_W'(d[`IFD_D_W-1 -: `IFD_SPLIT_W]);
        end else begin
            da = d;
            db = d;
        end
        return {da, db};
    endfunction

    task automatic compare_field(input string name, input logic [CMP_W-1:0] expected,
                                 input logic [CMP_W-1:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("error: test %s, %s expected %0h actual %0h",
                     cur_test, name, expected, actual);
        end
    endtask

    task automatic start_test(input string name);
        cur_test       = name;
        test_err_start = errors;
    endtask

    task automatic finish_test();
        tests_run++;
        if (errors == test_err_start) begin
            tests_passed++;
            $display("test %s: passed", cur_test);
        end else begin
            $display("test %s: failed with %0d errors", cur_test, errors - test_err_start);
        end
    endtask

    // One loader write with the shadow updated alongside
    task automatic write_imem(input ifd_pkg::iaddr_t addr, input ifd_pkg::instr_t word);
        ld_valid <= 1'b1;
        ld_addr  <= addr;
        ld_data  <= word;
        shadow_imem[addr] = word;
        @(posedge clock);
        ld_valid <= 1'b0;
    endtask

    task automatic write_table(input ifd_pkg::thread_t t, input logic [3:0] op,
                               input ifd_pkg::ctrl_t c);
        od_wren   <= 1'b1;
        od_thread <= t;
        od_opcode <= op;
        od_data   <= c;
        shadow_table[{t, op}] = c;
        @(posedge clock);
        od_wren <= 1'b0;
    endtask

    task automatic wait_for_bundles(input int total);
        while (received < total) begin
            @(posedge clock);
        end
    endtask

    // All credits held by the testbench means nothing in flight
    task automatic quiesce();
        credit_auto = 1'b0;
        while (!(pending == `IFD_CREDITS && credit_grant == 0)) begin
            @(posedge clock);
        end
    endtask

    // ------------------------------------------------------------------------
    // Monitor and credit return
    // ------------------------------------------------------------------------
    always @(posedge clock) begin : check_bundles
        ifd_pkg::thread_t          t;
        ifd_pkg::iaddr_t           addr;
        ifd_pkg::instr_t           w;
        ifd_pkg::ctrl_t            c;
        logic [2*`IFD_D_W-1:0]     e;
        if (out_valid === 1'b1) begin
            // Next bundle in strict rotation
            t    = exp_thread;
            addr = shadow_pc[t];
            w    = shadow_imem[addr];
            c    = shadow_table[{t, w.opcode}];
            e    = split_rule(w.d, c.split);
            compare_field("thread", t, out_thread);
            compare_field("ctrl", c, out_ctrl);
            compare_field("da", e[2*`IFD_D_W-1 -: `IFD_D_W], out_da);
            compare_field("db", e[`IFD_D_W-1:0], out_db);
            compare_field("a", w.a, out_a);
            compare_field("b", w.b, out_b);
            if (watch_armed && t == watch_thread && addr == watch_addr) begin
                watch_seen = 1'b1;
                compare_field("rewritten a", watch_word.a, out_a);
                compare_field("rewritten b", watch_word.b, out_b);
            end
            log_thread.push_back(out_thread);
            log_ctrl.push_back(out_ctrl);
            log_da.push_back(out_da);
            log_db.push_back(out_db);
            log_a.push_back(out_a);
            shadow_pc[t] = ifd_pkg::iaddr_t'((int'(addr) + 1) % `IFD_IMEM_DEPTH);
            exp_thread   = ifd_pkg::thread_t'((int'(t) + 1) % `IFD_THREADS);
            received++;
            pending++;
        end
        if (pending > 0 && (credit_auto || credit_grant > 0)) begin
            credit_return <= 1'b1;
            pending--;
            if (!credit_auto) begin
                credit_grant--;
            end
        end else begin
            credit_return <= 1'b0;
        end
    end

    always @(posedge clock) begin : watchdog
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles, %0d bundles seen",
                     TIMEOUT_CYCLES, received);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // Tests
    // ------------------------------------------------------------------------
    // Loader holds the port from reset release, so no fetch runs during load
    task automatic stream_all_threads();
        int i;
        start_test("stream_all_threads");
        for (i = 0; i < `IFD_IMEM_DEPTH; i++) begin
            ld_valid <= 1'b1;
            ld_addr  <= ifd_pkg::iaddr_t'(i);
            ld_data  <= random_instr();
            if (i < TABLE_DEPTH) begin
                od_wren   <= 1'b1;
                od_thread <= ifd_pkg::thread_t'(i >> `IFD_OPCODE_W);
                od_opcode <= i[3:0];
                od_data   <= `IFD_CTRL_W'(next_rand());
            end else begin
                od_wren <= 1'b0;
            end
            @(posedge clock);
            shadow_imem[i] = ld_data;
            if (i < TABLE_DEPTH) begin
                shadow_table[i] = od_data;
            end
        end
        ld_valid    <= 1'b0;
        od_wren     <= 1'b0;
        credit_auto = 1'b1;
        wait_for_bundles(64);
        quiesce();
        finish_test();
    endtask

    // Same word and opcode with a different control word per thread
    task automatic decode_per_thread();
        ifd_pkg::instr_t  w;
        ifd_pkg::ctrl_t   dctrl [`IFD_THREADS];
        int               t;
        int               i;
        int               base;
        start_test("decode_per_thread");
        w = random_instr();
        w.opcode = 4'hA;
        for (t = 0; t < `IFD_THREADS; t++) begin
            dctrl[t] = `IFD_CTRL_W'(next_rand());
            dctrl[t].split = 1'b0;
            dctrl[t].alu_op[1:0] = t[1:0];
            write_table(ifd_pkg::thread_t'(t), 4'hA, dctrl[t]);
            write_imem(shadow_pc[t], w);
        end
        base = received;
        credit_grant = `IFD_THREADS;
        wait_for_bundles(base + `IFD_THREADS);
        quiesce();
        for (i = 0; i < `IFD_THREADS; i++) begin
            compare_field("thread ctrl", dctrl[log_thread[base + i]], log_ctrl[base + i]);
            compare_field("shared a", w.a, log_a[base + i]);
        end
        finish_test();
    endtask

    // Each thread runs a split word and then a plain word with the same D
    task automatic split_addressing();
        logic [`IFD_D_W-1:0]    dvals [`IFD_THREADS];
        logic [2*`IFD_D_W-1:0]  e;
        ifd_pkg::instr_t        w;
        ifd_pkg::ctrl_t         c;
        int                     t;
        int                     i;
        int                     base;
        start_test("split_addressing");
        dvals[0] = 12'hFC0;
        dvals[1] = 12'hFFF;
        dvals[2] = 12'h03F;
        dvals[3] = 12'h5A5;
        for (t = 0; t < `IFD_THREADS; t++) begin
            c = `IFD_CTRL_W'(next_rand());
            c.split = 1'b1;
            write_table(ifd_pkg::thread_t'(t), 4'h5, c);
            c = `IFD_CTRL_W'(next_rand());
            c.split = 1'b0;
            write_table(ifd_pkg::thread_t'(t), 4'h6, c);
            w = random_instr();
            w.opcode = 4'h5;
            w.d = dvals[t];
            write_imem(shadow_pc[t], w);
            w.opcode = 4'h6;
            write_imem(ifd_pkg::iaddr_t'((int'(shadow_pc[t]) + 1) % `IFD_IMEM_DEPTH), w);
        end
        base = received;
        credit_grant = 2 * `IFD_THREADS;
        wait_for_bundles(base + 2 * `IFD_THREADS);
        quiesce();
        for (i = 0; i < 2 * `IFD_THREADS; i++) begin
            e = split_rule(dvals[log_thread[base + i]], i < `IFD_THREADS);
            compare_field("split da", e[2*`IFD_D_W-1 -: `IFD_D_W], log_da[base + i]);
            compare_field("split db", e[`IFD_D_W-1:0], log_db[base + i]);
            // High half at its maximum lands on the top of the DB window
            if (log_thread[base + i] == 1 && i < `IFD_THREADS) begin
                compare_field("max db", 12'h83F, log_db[base + i]);
            end
        end
        finish_test();
    endtask

    task automatic back_pressure();
        int i;
        int base;
        start_test("back_pressure");
        base = received;
        credit_grant = `IFD_CREDITS;
        wait_for_bundles(base + `IFD_CREDITS);
        quiesce();
        for (i = 0; i < 20; i++) begin
            @(posedge clock);
            checks++;
            if (out_valid !== 1'b0) begin
                errors++;
                $display("bundle arrived with no credit left in test %s", cur_test);
            end
        end
        compare_field("bundle count", base + `IFD_CREDITS, received);
        // Shadow PCs catch any lost or repeated word once credits resume
        credit_auto = 1'b1;
        wait_for_bundles(received + 16);
        quiesce();
        finish_test();
    endtask

    // Loader writes steal cycles from running fetches
    task automatic arbitration_during_fetch();
        ifd_pkg::iaddr_t  addr;
        ifd_pkg::instr_t  w;
        int               k;
        int               base;
        start_test("arbitration_during_fetch");
        base = received;
        credit_auto = 1'b1;
        for (k = 0; k < 8; k++) begin
            // Twelve words ahead is far beyond anything in flight
            addr = ifd_pkg::iaddr_t'((int'(shadow_pc[k % 4]) + 12) % `IFD_IMEM_DEPTH);
            w = random_instr();
            // Thread 1 is written twice and the later word is the one it runs
            if (k == 5) begin
                watch_thread = 1;
                watch_addr   = addr;
                watch_word   = w;
                watch_seen   = 1'b0;
                watch_armed  = 1'b1;
            end
            write_imem(addr, w);
            @(posedge clock);
        end
        wait_for_bundles(base + 64);
        quiesce();
        watch_armed = 1'b0;
        checks++;
        if (!watch_seen) begin
            errors++;
            $display("thread 1 never executed the rewritten word in test %s", cur_test);
        end
        finish_test();
    endtask

    // ------------------------------------------------------------------------
    // Sequence
    // ------------------------------------------------------------------------
    initial begin
        int t;
        rst_n         = 1'b0;
        ld_valid      = 1'b0;
        ld_addr       = '0;
        ld_data       = '0;
        od_wren       = 1'b0;
        od_thread     = '0;
        od_opcode     = '0;
        od_data       = '0;
        credit_return = 1'b0;
        exp_thread    = '0;
        for (t = 0; t < `IFD_IMEM_DEPTH; t++) begin
            shadow_imem[t] = '0;
        end
        for (t = 0; t < TABLE_DEPTH; t++) begin
            shadow_table[t] = '0;
        end
        for (t = 0; t < `IFD_THREADS; t++) begin
            shadow_pc[t] = ifd_pkg::iaddr_t'(t * `IFD_THREAD_STRIDE);
        end
        repeat (3) @(posedge clock);
        rst_n <= 1'b1;
        stream_all_threads();
        decode_per_thread();
        split_addressing();
        back_pressure();
        arbitration_during_fetch();
        $display("tests %0d, passed %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_passed, tests_run - tests_passed, checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
+incdir+include
hw/ifd_pkg.sv
hw/thread_sequencer.sv
hw/imem_arbiter.sv
hw/opcode_decoder.sv
hw/address_splitter.sv
hw/fetch_decode_top.sv
test/tb_fetch_decode.sv
